// ==== rtl/ra_pkg.sv ====
// Shared widths, register numbers and bus structs for the register access stage
// Stack addresses are flat, with no segment base added
// Operand kind OPK_MODRM is the only kind that takes its number from ModRM

package ra_pkg;

    localparam int WORD_W  = 32;
    localparam int NUM_GPR = 8;
    localparam int REG_W   = $clog2(NUM_GPR);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_num_t;
    typedef logic [2:0]        opk_t;
    typedef logic [1:0]        size_t;

    // Bit 1 pop, bit 0 push
    typedef logic [1:0]        stack_op_t;

    // General register numbers with a fixed role
    localparam reg_num_t REG_ESP = 3'd4;
    localparam reg_num_t REG_ESI = 3'd6;
    localparam reg_num_t REG_EDI = 3'd7;

    // Operand kind that reads ModRM bits 2..0
    localparam opk_t OPK_MODRM = 3'd4;

    // Operand size codes
    localparam size_t SZ_NONE  = 2'd0;
    localparam size_t SZ_BYTE  = 2'd1;
    localparam size_t SZ_WORD  = 2'd2;
    localparam size_t SZ_DWORD = 2'd3;

    typedef struct packed {
        size_t     size;
        opk_t      op0_kind;
        opk_t      op1_kind;
        reg_num_t  op0_reg;
        reg_num_t  op1_reg;
        logic [7:0] modrm;
        stack_op_t stack_op;
        logic      movs;
        logic      writes_op0;
    } dec_req_t;

    typedef struct packed {
        reg_num_t op0_reg;
        reg_num_t op1_reg;
        word_t    op0_val;
        word_t    op1_val;
        word_t    stack_addr;
        word_t    esi;
        word_t    edi;
    } ra_out_t;

    typedef struct packed {
        logic     en;
        reg_num_t num;
        word_t    data;
    } wb_req_t;

endpackage

// ==== rtl/operand_select.sv ====
// Resolves operand register numbers and tracks pending general register writes
// One busy bit per register, set at acceptance and cleared by writeback
// Every writeback is expected to match an earlier set, flush drops all of them

`timescale 1ns/1ps

module operand_select (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  ra_pkg::dec_req_t d_req,
    input  logic             accept,
    input  ra_pkg::wb_req_t  wb,
    output ra_pkg::reg_num_t op0_num,
    output ra_pkg::reg_num_t op1_num,
    output logic             hazard
);

    logic [ra_pkg::NUM_GPR-1:0] busy_q;
    logic                       use_modrm0;
    logic                       use_modrm1;
    logic                       op_busy;
    logic                       esp_busy;
    logic                       str_busy;

    // ModRM r/m field replaces the request's own register number
    assign use_modrm0 = (d_req.op0_kind == ra_pkg::OPK_MODRM);
    assign use_modrm1 = (d_req.op1_kind == ra_pkg::OPK_MODRM);

    assign op0_num = use_modrm0 ? d_req.modrm[2:0] : d_req.op0_reg;
    assign op1_num = use_modrm1 ? d_req.modrm[2:0] : d_req.op1_reg;

    // Registers the instruction touches
    assign op_busy  = busy_q[op0_num] | busy_q[op1_num];
    assign esp_busy = (d_req.stack_op != '0) & busy_q[ra_pkg::REG_ESP];
    assign str_busy = d_req.movs & (busy_q[ra_pkg::REG_ESI] | busy_q[ra_pkg::REG_EDI]);

    assign hazard = op_busy | esp_busy | str_busy;

    // Scoreboard
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else if (flush) begin
            busy_q <= '0;
        end else begin
            if (wb.en) begin
                busy_q[wb.num] <= 1'b0;
            end
            // A new pending write outranks a clear of the same register
            if (accept && d_req.writes_op0) begin
                busy_q[op0_num] <= 1'b1;
            end
        end
    end

    // Writeback must retire a write that was actually issued
    property p_wb_clears_busy;
        @(posedge clk) disable iff (!rst_n)
        wb.en |-> busy_q[wb.num];
    endproperty

    a_wb_clears_busy : assert property (p_wb_clears_busy)
        else $error("writeback to r%0d with no pending write", wb.num);

endmodule

// ==== rtl/pointer_update.sv ====
// Speculative working ESP for push and pop, plus MOVS pointer step
// Working ESP follows any writeback to ESP, flush reloads the committed value
// If both stack_op bits are set the request is treated as a pop

`timescale 1ns/1ps

module pointer_update (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             df,
    input  ra_pkg::dec_req_t d_req,
    input  logic             accept,
    input  ra_pkg::wb_req_t  wb,
    input  ra_pkg::word_t    commit_esp,
    input  ra_pkg::word_t    cur_esi,
    input  ra_pkg::word_t    cur_edi,
    output ra_pkg::word_t    stack_addr,
    output ra_pkg::word_t    next_esi,
    output ra_pkg::word_t    next_edi
);

    ra_pkg::word_t esp_q;
    ra_pkg::word_t stack_step;
    ra_pkg::word_t push_esp;
    ra_pkg::word_t pop_esp;
    ra_pkg::word_t str_delta;
    logic          is_pop;
    logic          is_push;
    logic          wb_esp;

    assign is_pop  = d_req.stack_op[1];
    assign is_push = d_req.stack_op[0] & ~is_pop;
    assign wb_esp  = wb.en && (wb.num == ra_pkg::REG_ESP);

    // Words move the stack by 2, everything else by 4
    assign stack_step = (d_req.size == ra_pkg::SZ_WORD) ? 32'd2 : 32'd4;
    assign push_esp   = esp_q - stack_step;
    assign pop_esp    = esp_q + stack_step;

    // Push addresses the new top, pop and non-stack ops the current one
    assign stack_addr = is_push ? push_esp : esp_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            esp_q <= '0;
        end else if (wb_esp) begin
            esp_q <= wb.data;
        end else if (flush) begin
            esp_q <= commit_esp;
        end else if (accept && is_pop) begin
            esp_q <= pop_esp;
        end else if (accept && is_push) begin
            esp_q <= push_esp;
        end
    end

    // String pointer step by operand size
    always_comb begin
        case (d_req.size)
            ra_pkg::SZ_NONE:  str_delta = 32'd0;
            ra_pkg::SZ_BYTE:  str_delta = 32'd1;
            ra_pkg::SZ_WORD:  str_delta = 32'd2;
            ra_pkg::SZ_DWORD: str_delta = 32'd4;
        endcase
    end

    // DF set walks the strings downwards
    assign next_esi = df ? (cur_esi - str_delta) : (cur_esi + str_delta);
    assign next_edi = df ? (cur_edi - str_delta) : (cur_edi + str_delta);

    property p_esp_step;
        @(posedge clk) disable iff (!rst_n)
        (accept && (is_push || is_pop) && !wb_esp && !flush) |=>
            ((esp_q - $past(esp_q)) inside
                {32'd2, 32'd4, 32'hffff_fffe, 32'hffff_fffc});
    endproperty

    a_esp_step : assert property (p_esp_step)
        else $error("working ESP moved by an illegal amount");

endmodule

// ==== rtl/gpr_file.sv ====
// Eight 32-bit general registers, all cleared at reset
// One full width writeback port plus the MOVS update of ESI and EDI
// Writeback wins when both hit the same register

`timescale 1ns/1ps

module gpr_file (
    input  logic                                clk,
    input  logic                                rst_n,
    input  ra_pkg::wb_req_t                     wb,
    input  logic                                str_en,
    input  ra_pkg::word_t                       next_esi,
    input  ra_pkg::word_t                       next_edi,
    output ra_pkg::word_t [ra_pkg::NUM_GPR-1:0] regs
);

    logic wb_hits_str;

    assign wb_hits_str = wb.en &&
        ((wb.num == ra_pkg::REG_ESI) || (wb.num == ra_pkg::REG_EDI));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else begin
            // String pointer step of an accepted MOVS
            if (str_en) begin
                regs[ra_pkg::REG_ESI] <= next_esi;
                regs[ra_pkg::REG_EDI] <= next_edi;
            end
            // Later assignment takes priority
            if (wb.en) begin
                regs[wb.num] <= wb.data;
            end
        end
    end

    // Scoreboard keeps MOVS away from a pending ESI or EDI write
    property p_no_str_wb_clash;
        @(posedge clk) disable iff (!rst_n)
        !(str_en && wb_hits_str);
    endproperty

    a_no_str_wb_clash : assert property (p_no_str_wb_clash)
        else $error("MOVS step and writeback to r%0d on the same edge", wb.num);

endmodule

// ==== rtl/operand_stage.sv ====
// Valid/ready handshake and the single output register of the stage
// r_out holds its value until taken, flush drops a pending item
// ESI and EDI in the result are the values before the MOVS step

`timescale 1ns/1ps

module operand_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,
    input  logic                                d_valid,
    input  ra_pkg::dec_req_t                    d_req,
    input  logic                                hazard,
    input  ra_pkg::reg_num_t                    op0_num,
    input  ra_pkg::reg_num_t                    op1_num,
    input  ra_pkg::word_t [ra_pkg::NUM_GPR-1:0] regs,
    input  ra_pkg::word_t                       stack_addr,
    output logic                                d_ready,
    output logic                                accept,
    output logic                                str_en,
    output logic                                r_valid,
    input  logic                                r_ready,
    output ra_pkg::ra_out_t                     r_out
);

    ra_pkg::ra_out_t out_d;

    // Room when empty or draining, and nothing accepted on a flush cycle
    assign d_ready = !flush && (!r_valid || r_ready) && !hazard;
    assign accept  = d_valid && d_ready;
    assign str_en  = accept && d_req.movs;

    always_comb begin
        out_d.op0_reg    = op0_num;
        out_d.op1_reg    = op1_num;
        out_d.op0_val    = regs[op0_num];
        out_d.op1_val    = regs[op1_num];
        out_d.stack_addr = stack_addr;
        out_d.esi        = regs[ra_pkg::REG_ESI];
        out_d.edi        = regs[ra_pkg::REG_EDI];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (flush) begin
            r_valid <= 1'b0;
        end else if (accept) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_out <= '0;
        end else if (accept) begin
            r_out <= out_d;
        end
    end

    property p_hold_under_stall;
        @(posedge clk) disable iff (!rst_n)
        (r_valid && !r_ready) |=> $stable(r_out);
    endproperty

    a_hold_under_stall : assert property (p_hold_under_stall)
        else $error("r_out changed while stalled");

endmodule

// ==== rtl/ra_top.sv ====
// Register access stage, decoded request in, operand values out
// One instruction per cycle when the next stage keeps r_ready high
// Writeback port is full width only, no byte or word merge

`timescale 1ns/1ps

module ra_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             df,
    input  logic             d_valid,
    output logic             d_ready,
    input  ra_pkg::dec_req_t d_req,
    output logic             r_valid,
    input  logic             r_ready,
    output ra_pkg::ra_out_t  r_out,
    input  ra_pkg::wb_req_t  wb
);

    logic                                    accept;
    logic                                    hazard;
    logic                                    str_en;
    ra_pkg::reg_num_t                        op0_num;
    ra_pkg::reg_num_t                        op1_num;
    ra_pkg::word_t                           stack_addr;
    ra_pkg::word_t                           next_esi;
    ra_pkg::word_t                           next_edi;
    ra_pkg::word_t [ra_pkg::NUM_GPR-1:0]     regs;

    // Register numbers and write scoreboard
    operand_select u_operand_select (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .d_req   (d_req),
        .accept  (accept),
        .wb      (wb),
        .op0_num (op0_num),
        .op1_num (op1_num),
        .hazard  (hazard)
    );

    // Working ESP and string pointer step
    pointer_update u_pointer_update (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .df         (df),
        .d_req      (d_req),
        .accept     (accept),
        .wb         (wb),
        .commit_esp (regs[ra_pkg::REG_ESP]),
        .cur_esi    (regs[ra_pkg::REG_ESI]),
        .cur_edi    (regs[ra_pkg::REG_EDI]),
        .stack_addr (stack_addr),
        .next_esi   (next_esi),
        .next_edi   (next_edi)
    );

    gpr_file u_gpr_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb       (wb),
        .str_en   (str_en),
        .next_esi (next_esi),
        .next_edi (next_edi),
        .regs     (regs)
    );

    // Handshake and output register
    operand_stage u_operand_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .d_valid    (d_valid),
        .d_req      (d_req),
        .hazard     (hazard),
        .op0_num    (op0_num),
        .op1_num    (op1_num),
        .regs       (regs),
        .stack_addr (stack_addr),
        .d_ready    (d_ready),
        .accept     (accept),
        .str_en     (str_en),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r_out      (r_out)
    );

endmodule

// ==== tb/ra_checker.sv ====
// Watches the register access stage and compares its outputs with expected values
// Expected results arrive through expect_item, in acceptance order
// Expected d_ready and r_valid come from the testbench model each cycle

`timescale 1ns/1ps

module ra_checker (
    input logic             clk,
    input logic             rst_n,
    input logic             d_ready,
    input logic             r_valid,
    input logic             r_ready,
    input ra_pkg::ra_out_t  r_out,
    input logic             exp_ready,
    input logic             exp_valid
);

    ra_pkg::ra_out_t exp_q[$];
    ra_pkg::ra_out_t prev_out;
    logic            prev_hold;
    int              value_errs;
    int              hs_errs;

    initial begin
        value_errs = 0;
        hs_errs    = 0;
        prev_hold  = 1'b0;
        prev_out   = '0;
    end

    task automatic expect_item(input ra_pkg::ra_out_t item);
        exp_q.push_back(item);
    endtask

    // A flushed result never leaves the stage
    task automatic drop_last();
        if (exp_q.size() > 0) begin
            exp_q.pop_back();
        end
    endtask

    always @(posedge clk) begin
        ra_pkg::ra_out_t exp;
        if (rst_n) begin
            if (d_ready !== exp_ready) begin
                hs_errs++;
                $display("ERR %0t: d_ready is %b, expected %b", $time, d_ready, exp_ready);
            end
            if (r_valid !== exp_valid) begin
                hs_errs++;
                $display("ERR %0t: r_valid is %b, expected %b", $time, r_valid, exp_valid);
            end
            // Held item must not move under back-pressure
            if (prev_hold && (r_out !== prev_out)) begin
                value_errs++;
                $display("ERR %0t: r_out changed while held, %h -> %h",
                         $time, prev_out, r_out);
            end
            if (r_valid && r_ready) begin
                if (exp_q.size() == 0) begin
                    hs_errs++;
                    $display("ERR %0t: result %h delivered, none expected", $time, r_out);
                end else begin
                    exp = exp_q.pop_front();
                    if (r_out !== exp) begin
                        value_errs++;
                        $display("ERR %0t: r_out %h, expected %h", $time, r_out, exp);
                    end
                end
            end
            prev_hold = r_valid && !r_ready;
            prev_out  = r_out;
        end
    end

endmodule

// ==== tb/ra_tb.sv ====
// Table driven testbench for ra_top, inputs change on the falling edge
// A reference model predicts d_ready, r_valid and each accepted result
// Every writeback in the table follows a write issued earlier to that register

`timescale 1ns/1ps

module ra_tb;

    localparam int CLK_NS  = 4;
    localparam int MAX_ENT = 80;

    // Stall codes: 0 ready high, 1 random ready, 2 ready low
    typedef struct packed {
        logic             valid;
        ra_pkg::dec_req_t req;
        logic             df;
        ra_pkg::wb_req_t  wb;
        logic [1:0]       stall;
        logic             flush;
    } entry_t;

    logic             clk;
    logic             rst_n;
    logic             flush;
    logic             df;
    logic             d_valid;
    logic             d_ready;
    ra_pkg::dec_req_t d_req;
    logic             r_valid;
    logic             r_ready;
    ra_pkg::ra_out_t  r_out;
    ra_pkg::wb_req_t  wb;
    logic             exp_ready;
    logic             exp_valid;

    // Reference model state
    ra_pkg::word_t    m_regs [ra_pkg::NUM_GPR];
    logic [7:0]       m_busy;
    ra_pkg::word_t    m_esp;
    logic             m_rv;
    logic [31:0]      seed;

    entry_t           tbl [MAX_ENT];
    int               n_ent;
    int               wd_ns;

    ra_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .df      (df),
        .d_valid (d_valid),
        .d_ready (d_ready),
        .d_req   (d_req),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_out   (r_out),
        .wb      (wb)
    );

    ra_checker chk_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .d_ready   (d_ready),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r_out     (r_out),
        .exp_ready (exp_ready),
        .exp_valid (exp_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic ra_pkg::dec_req_t mk_req(
        input ra_pkg::size_t sz, input ra_pkg::opk_t k0, input ra_pkg::opk_t k1,
        input ra_pkg::reg_num_t r0, input ra_pkg::reg_num_t r1, input logic [7:0] modrm,
        input ra_pkg::stack_op_t st, input logic mv, input logic wr);
        ra_pkg::dec_req_t q;
        q.size       = sz;
        q.op0_kind   = k0;
        q.op1_kind   = k1;
        q.op0_reg    = r0;
        q.op1_reg    = r1;
        q.modrm      = modrm;
        q.stack_op   = st;
        q.movs       = mv;
        q.writes_op0 = wr;
        return q;
    endfunction

    function automatic ra_pkg::wb_req_t mk_wb(input ra_pkg::reg_num_t num,
                                              input ra_pkg::word_t data);
        ra_pkg::wb_req_t w;
        w.en   = 1'b1;
        w.num  = num;
        w.data = data;
        return w;
    endfunction

    task automatic add(input logic valid, input ra_pkg::dec_req_t req, input logic dfv,
                       input ra_pkg::wb_req_t w, input logic [1:0] st, input logic fl);
        tbl[n_ent].valid = valid;
        tbl[n_ent].req   = req;
        tbl[n_ent].df    = dfv;
        tbl[n_ent].wb    = w;
        tbl[n_ent].stall = st;
        tbl[n_ent].flush = fl;
        n_ent++;
    endtask

    task automatic build_table();
        ra_pkg::word_t v;
        ra_pkg::dec_req_t nop;
        nop = '0;
        // Load every register through a write and its writeback
        for (int r = 0; r < 8; r++) begin
            v = 32'h1000_0000 + 32'(r) * 32'h0011_0101;
            if (r == 4) v = 32'h0000_8000;
            if (r == 6) v = 32'h0000_2000;
            if (r == 7) v = 32'h0000_3000;
            add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'(r), 3'(r), 8'h00, 2'b00, 1'b0, 1'b1),
                1'b0, '0, 2'd0, 1'b0);
            add(1'b0, nop, 1'b0, mk_wb(3'(r), v), 2'd0, 1'b0);
        end
        // Reads with op0 from ModRM and op1 from the request field
        for (int r = 0; r < 8; r++) begin
            add(1'b1, mk_req(2'd3, 3'd4, 3'd0, 3'd0, 3'(r + 3), 8'hc0 | 8'(r),
                2'b00, 1'b0, 1'b0), 1'b0, '0, 2'd0, 1'b0);
        end
        // Readers blocked until the writeback lands
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd2, 3'd2, 8'h00, 2'b00, 1'b0, 1'b1),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd1, 3'd2, 8'h00, 2'b00, 1'b0, 1'b0),
            1'b0, mk_wb(3'd2, 32'hcafe_0002), 2'd0, 1'b0);
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd5, 3'd5, 8'h00, 2'b00, 1'b0, 1'b1),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd3, 3'd4, 3'd0, 3'd0, 3'd0, 8'h05, 2'b00, 1'b0, 1'b0),
            1'b0, mk_wb(3'd5, 32'hbeef_0005), 2'd0, 1'b0);
        // Stack sequence, then a restart from a written ESP
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b01, 1'b0, 1'b0),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd2, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b01, 1'b0, 1'b0),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd2, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b10, 1'b0, 1'b0),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b10, 1'b0, 1'b0),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b01, 1'b0, 1'b0),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd4, 3'd0, 8'h00, 2'b00, 1'b0, 1'b1),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b0, nop, 1'b0, mk_wb(3'd4, 32'h0000_9000), 2'd0, 1'b0);
        add(1'b1, mk_req(2'd2, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b01, 1'b0, 1'b0),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b10, 1'b0, 1'b0),
            1'b0, '0, 2'd0, 1'b0);
        // MOVS steps by size and direction
        add(1'b1, mk_req(2'd1, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b00, 1'b1, 1'b0),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd2, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b00, 1'b1, 1'b0),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b00, 1'b1, 1'b0),
            1'b1, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd0, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b00, 1'b1, 1'b0),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd2, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b00, 1'b1, 1'b0),
            1'b1, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd1, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b00, 1'b1, 1'b0),
            1'b0, '0, 2'd0, 1'b0);
        // Mixed traffic under random back-pressure
        for (int i = 0; i < 12; i++) begin
            if (i % 3 == 0) begin
                add(1'b1, mk_req(2'd3, 3'd4, 3'd0, 3'd0, 3'(i), 8'hc0 | 8'(i + 1),
                    2'b00, 1'b0, 1'b0), 1'b0, '0, 2'd1, 1'b0);
            end else if (i % 3 == 1) begin
                add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00,
                    (i % 2 == 1) ? 2'b01 : 2'b10, 1'b0, 1'b0), 1'b0, '0, 2'd1, 1'b0);
            end else begin
                add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b00, 1'b1, 1'b0),
                    1'b0, '0, 2'd1, 1'b0);
            end
        end
        // Flush drops a held result, a pending write and the working ESP
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd3, 3'd3, 8'h00, 2'b00, 1'b0, 1'b1),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b01, 1'b0, 1'b0),
            1'b0, '0, 2'd0, 1'b0);
        add(1'b0, nop, 1'b0, '0, 2'd0, 1'b0);
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd1, 3'd1, 8'h00, 2'b00, 1'b0, 1'b0),
            1'b0, '0, 2'd2, 1'b0);
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd3, 3'd0, 8'h00, 2'b00, 1'b0, 1'b0),
            1'b0, '0, 2'd0, 1'b1);
        add(1'b1, mk_req(2'd3, 3'd0, 3'd0, 3'd0, 3'd0, 8'h00, 2'b01, 1'b0, 1'b0),
            1'b0, '0, 2'd0, 1'b0);
    endtask

    // Drives one cycle and advances the model to the state after the next edge
    task automatic step(input entry_t e, input logic first, output logic acc);
        ra_pkg::reg_num_t n0;
        ra_pkg::reg_num_t n1;
        ra_pkg::word_t    step_w;
        ra_pkg::word_t    delta;
        ra_pkg::ra_out_t  item;
        logic             haz;
        logic             ready;
        logic             push;
        logic             pop;
        @(negedge clk);
        d_valid = e.valid;
        d_req   = e.req;
        df      = e.df;
        wb      = first ? e.wb : '0;
        flush   = first & e.flush;
        seed    = lcg_next(seed);
        case (e.stall)
            2'd1:    r_ready = seed[17];
            2'd2:    r_ready = 1'b0;
            default: r_ready = 1'b1;
        endcase
        if (flush) r_ready = 1'b0;

        n0 = (d_req.op0_kind == ra_pkg::OPK_MODRM) ? d_req.modrm[2:0] : d_req.op0_reg;
        n1 = (d_req.op1_kind == ra_pkg::OPK_MODRM) ? d_req.modrm[2:0] : d_req.op1_reg;
        haz = m_busy[n0] | m_busy[n1] | ((d_req.stack_op != 2'b00) & m_busy[4]) |
              (d_req.movs & (m_busy[6] | m_busy[7]));
        ready = !flush && (!m_rv || r_ready) && !haz;
        acc = d_valid && ready;
        exp_ready = ready;
        exp_valid = m_rv;
        push   = (d_req.stack_op == 2'b01);
        pop    = d_req.stack_op[1];
        step_w = (d_req.size == 2'd2) ? 32'd2 : 32'd4;
        delta  = (d_req.size == 2'd3) ? 32'd4 : {30'd0, d_req.size};

        if (acc) begin
            item.op0_reg    = n0;
            item.op1_reg    = n1;
            item.op0_val    = m_regs[n0];
            item.op1_val    = m_regs[n1];
            item.stack_addr = push ? (m_esp - step_w) : m_esp;
            item.esi        = m_regs[6];
            item.edi        = m_regs[7];
            chk_i.expect_item(item);
        end
        if (flush && m_rv) chk_i.drop_last();

        if (wb.en && (wb.num == 3'd4)) m_esp = wb.data;
        else if (flush) m_esp = m_regs[4];
        else if (acc && pop) m_esp = m_esp + step_w;
        else if (acc && push) m_esp = m_esp - step_w;

        if (flush) begin
            m_busy = '0;
        end else begin
            if (wb.en) m_busy[wb.num] = 1'b0;
            if (acc && d_req.writes_op0) m_busy[n0] = 1'b1;
        end
        if (acc && d_req.movs) begin
            m_regs[6] = df ? (m_regs[6] - delta) : (m_regs[6] + delta);
            m_regs[7] = df ? (m_regs[7] - delta) : (m_regs[7] + delta);
        end
        if (wb.en) m_regs[wb.num] = wb.data;
        m_rv = flush ? 1'b0 : (acc ? 1'b1 : (r_ready ? 1'b0 : m_rv));
    endtask

    initial begin
        logic   acc;
        logic   first;
        entry_t idle;
        int     total;
        rst_n     = 1'b0;
        flush     = 1'b0;
        df        = 1'b0;
        d_valid   = 1'b0;
        d_req     = '0;
        r_ready   = 1'b0;
        wb        = '0;
        exp_ready = 1'b1;
        exp_valid = 1'b0;
        for (int r = 0; r < ra_pkg::NUM_GPR; r++) m_regs[r] = '0;
        m_busy = '0;
        m_esp  = '0;
        m_rv   = 1'b0;
        seed   = 32'hd9c4;
        n_ent  = 0;
        idle   = '0;
        build_table();

        wd_ns = 20 * n_ent * CLK_NS + 500;
        fork
            begin
                #(wd_ns);
                $display("Timeout: the stage stopped making progress");
                $display("TESTS FAILED");
                $finish;
            end
        join_none

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < n_ent; i++) begin
            first = 1'b1;
            do begin
                step(tbl[i], first, acc);
                first = 1'b0;
            end while (tbl[i].valid && !acc);
        end
        // Drain what is still in flight
        while (chk_i.exp_q.size() != 0) begin
            step(idle, 1'b1, acc);
        end
        repeat (2) step(idle, 1'b1, acc);

        total = chk_i.value_errs + chk_i.hs_errs;
        $display("value errors %0d, handshake errors %0d", chk_i.value_errs, chk_i.hs_errs);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/ra_pkg.sv
rtl/operand_select.sv
rtl/pointer_update.sv
rtl/gpr_file.sv
rtl/operand_stage.sv
rtl/ra_top.sv
tb/ra_checker.sv
tb/ra_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module ra_tb -Mdir obj_dir -o ra_sim
	obj_dir/ra_sim | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
